// ==== cart_config.svh ====
/*
 * Cartridge controller constants
 * Store geometry, bank window, ROM header offsets and detection defaults
 */

`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// ===========================================================================
// Store and banking geometry
// ===========================================================================

// 16K words of on-chip ROM store
`define CART_STORE_AW 14

// Word address bits inside one bank window
`define CART_WIN_AW 8

// SSF2 style bank registers
`define CART_BANK_COUNT 8
`define CART_BANK_W 6

// ===========================================================================
// ROM header layout
// ===========================================================================

// Serial number words, byte addresses
`define CART_HDR_SERIAL_FIRST 'h182
`define CART_HDR_SERIAL_LAST 'h188

// Write to this address commits the lookup
`define CART_HDR_DECIDE 'h190

// Menacer style sensor delay for titles not in the table
`define CART_GUN_DELAY_DEFAULT 8'd44

`endif

// ==== cart_pkg.sv ====
/*
 * Cartridge controller types
 * Download beats, store handshake, 68000 bus and detection results
 */

`include "cart_config.svh"

package cart_pkg;

	// One host download beat, byte address and 16-bit word
	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_word_t;

	// Store request, transfer starts when req toggles
	typedef struct packed {
		logic [`CART_STORE_AW-1:0] addr;
		logic [15:0]               wdata;
		logic                      we;
		logic                      req;
	} rom_req_t;

	// Store response, done when ack equals req
	typedef struct packed {
		logic [15:0] rdata;
		logic        ack;
	} rom_rsp_t;

	// 68000 cartridge bus as seen by the cartridge
	typedef struct packed {
		logic [23:1] addr;
		logic [15:0] data_wr;
		logic        cs;
		logic        oe;
		logic        lwr;
		logic        uwr;
		logic        time_sel;
	} cart_bus_t;

	// Per-title settings taken from the header serial
	typedef struct packed {
		logic       ym2612_quirk;
		logic       gun_type;
		logic [7:0] gun_sensor_delay;
	} cart_quirk_t;

	typedef logic [`CART_BANK_W-1:0] bank_t;

endpackage

// ==== cart_loader.sv ====
/*
 * ROM download producer
 * Turns host words into store writes and tracks ROM size and address mask
 */

`timescale 1ns/10ps
`include "cart_config.svh"

module cart_loader (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cart_dl,
	input  cart_pkg::dl_word_t        dl,
	output cart_pkg::rom_req_t        req,
	input  cart_pkg::rom_rsp_t        rsp,
	output logic                      cart_dl_wait,
	output logic [`CART_STORE_AW-1:0] rom_mask
);

	logic                      old_dl;
	logic                      dl_rise;
	logic                      beat;
	logic [`CART_STORE_AW-1:0] rom_sz;
	logic [`CART_STORE_AW-1:0] base;
	logic [`CART_STORE_AW-1:0] mask_base;
	logic [`CART_STORE_AW-1:0] wr_addr;
	logic [15:0]               wr_data;
	logic                      req_tog;

	assign dl_rise = cart_dl & ~old_dl;
	assign beat    = cart_dl & dl.wr;

	// A beat in the very first download cycle already sees the cleared state
	assign base      = dl_rise ? '0 : rom_sz;
	assign mask_base = dl_rise ? '0 : rom_mask;

	// ========================================================================
	// Size, mask and handshake
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			old_dl       <= 1'b0;
			req_tog      <= 1'b0;
			cart_dl_wait <= 1'b0;
		end else begin
			old_dl <= cart_dl;

			if (dl_rise) begin
				rom_sz   <= '0;
				rom_mask <= '0;
			end

			if (beat) begin
				rom_sz       <= base + 1'b1;
				rom_mask     <= mask_base | base;
				req_tog      <= ~req_tog;
				cart_dl_wait <= 1'b1;
			end else if (cart_dl_wait && (req_tog == rsp.ack)) begin
				// Write landed in the store
				cart_dl_wait <= 1'b0;
			end
		end
	end

	// Write payload, held stable while the request is in flight
	always_ff @(posedge clk) begin
		if (beat) begin
			wr_addr <= base;
			wr_data <= dl.data;
		end
	end

	assign req = '{addr: wr_addr, wdata: wr_data, we: 1'b1, req: req_tog};

endmodule

// ==== cart_detect.sv ====
/*
 * ROM header detection
 * Captures the serial during download and looks up sound and light-gun settings
 */

`timescale 1ns/10ps
`include "cart_config.svh"

module cart_detect (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cart_dl,
	input  cart_pkg::dl_word_t     dl,
	output cart_pkg::cart_quirk_t  quirks
);

	localparam int SERIAL_WORDS =
		(`CART_HDR_SERIAL_LAST - `CART_HDR_SERIAL_FIRST) / 2 + 1;

	logic                      old_dl;
	logic                      beat;
	logic [16*SERIAL_WORDS-1:0] serial;

	// Table of known titles
	function automatic cart_pkg::cart_quirk_t lookup(input logic [63:0] id);
		cart_pkg::cart_quirk_t q;
		q.ym2612_quirk     = 1'b0;
		q.gun_type         = 1'b0;
		q.gun_sensor_delay = `CART_GUN_DELAY_DEFAULT;
		case (id)
			"T-35036 ", "T-25073 ", "MK-1137-", "G-4034  ": q.ym2612_quirk = 1'b1;
			default: q.ym2612_quirk = 1'b0;
		endcase
		// Light-gun titles and their sensor offsets
		case (id)
			"MK-1533 ": q.gun_sensor_delay = 8'd100;
			"T-95096-": begin
				q.gun_type         = 1'b1;
				q.gun_sensor_delay = 8'd52;
			end
			"T-95136-": begin
				q.gun_type         = 1'b1;
				q.gun_sensor_delay = 8'd30;
			end
			"MK-1658 ": q.gun_sensor_delay = 8'd120;
			"T-081156": q.gun_sensor_delay = 8'd126;
			default: q.gun_type = 1'b0;
		endcase
		return q;
	endfunction

	assign beat = cart_dl & dl.wr;

	// Host words carry the even byte in the low half, so swap
	always_ff @(posedge clk) begin
		if (beat) begin
			for (int i = 0; i < SERIAL_WORDS; i++) begin
				if (dl.addr == `CART_HDR_SERIAL_FIRST + 2 * i)
					serial[16*(SERIAL_WORDS-1-i) +: 16] <= {dl.data[7:0], dl.data[15:8]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			old_dl <= 1'b0;
			quirks <= '{1'b0, 1'b0, `CART_GUN_DELAY_DEFAULT};
		end else begin
			old_dl <= cart_dl;
			if (cart_dl && !old_dl)
				quirks <= '{1'b0, 1'b0, `CART_GUN_DELAY_DEFAULT};
			if (beat && dl.addr == `CART_HDR_DECIDE)
				quirks <= lookup(serial);
		end
	end

endmodule

// ==== rom_store.sv ====
/*
 * On-chip ROM word store
 * Dual-port memory, one toggle handshake transfer in flight per port
 */

`timescale 1ns/10ps
`include "cart_config.svh"

module rom_store (
	input  logic               clk,
	input  cart_pkg::rom_req_t req_a,
	output cart_pkg::rom_rsp_t rsp_a,
	input  cart_pkg::rom_req_t req_b,
	output cart_pkg::rom_rsp_t rsp_b
);

	localparam int PORTS = 2;

	logic [15:0]        mem [2**`CART_STORE_AW];
	cart_pkg::rom_req_t req [PORTS];
	logic [PORTS-1:0]   ack;
	logic [15:0]        rdata [PORTS];

	// Port 0 is the loader, port 1 the bus mapper
	assign req[0] = req_a;
	assign req[1] = req_b;

	// ========================================================================
	// Ack is the request toggle delayed by one cycle, so it
	// settles to the client's reset value without a reset of its own
	// ========================================================================

	always_ff @(posedge clk) begin
		for (int p = 0; p < PORTS; p++) begin
			ack[p] <= req[p].req;
			if (req[p].req != ack[p]) begin
				if (req[p].we)
					mem[req[p].addr] <= req[p].wdata;
				else
					rdata[p] <= mem[req[p].addr];
			end
		end
	end

	assign rsp_a = '{rdata: rdata[0], ack: ack[0]};
	assign rsp_b = '{rdata: rdata[1], ack: ack[1]};

endmodule

// ==== cart_mapper.sv ====
/*
 * Cartridge bus mapper
 * SSF2 bank registers, address translation and ROM reads with dtack
 */

`timescale 1ns/10ps
`include "cart_config.svh"

module cart_mapper (
	input  logic                      clk,
	input  logic                      reset,
	input  cart_pkg::cart_bus_t       bus,
	input  logic [`CART_STORE_AW-1:0] rom_mask,
	output cart_pkg::rom_req_t        req,
	input  cart_pkg::rom_rsp_t        rsp,
	output logic [15:0]               cart_data,
	output logic                      cart_dtack
);

	localparam int SEL_W = $clog2(`CART_BANK_COUNT);
	localparam int AW    = `CART_STORE_AW;

	cart_pkg::bank_t  bank [`CART_BANK_COUNT];
	logic             bank_use;
	logic [SEL_W-1:0] win_sel;
	logic [AW-1:0]    map_addr;
	logic [AW-1:0]    rd_addr;
	logic             old_oe;
	logic             rd_pending;
	logic             req_tog;
	logic             rd_start;
	logic             rd_done;

	// ========================================================================
	// Bank registers, written in the /TIME area
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CART_BANK_COUNT; i++)
				bank[i] <= cart_pkg::bank_t'(i);
			bank_use <= 1'b0;
		end else if (bus.lwr && bus.time_sel && bus.addr[SEL_W:1] != '0) begin
			bank[bus.addr[SEL_W:1]] <= bus.data_wr[`CART_BANK_W-1:0];
			bank_use                <= 1'b1;
		end
	end

	// Window select sits right above the window offset
	assign win_sel  = bus.addr[`CART_WIN_AW+SEL_W:`CART_WIN_AW+1];
	assign map_addr = (bank_use ? {bank[win_sel], bus.addr[`CART_WIN_AW:1]}
	                            : bus.addr[AW:1]) & rom_mask;

	// ========================================================================
	// Read path
	// ========================================================================

	assign rd_start = bus.oe & ~old_oe & bus.cs & ~rd_pending;
	assign rd_done  = rd_pending & (req_tog == rsp.ack);

	always_ff @(posedge clk) begin
		if (reset) begin
			old_oe     <= 1'b0;
			rd_pending <= 1'b0;
			req_tog    <= 1'b0;
			cart_dtack <= 1'b0;
		end else begin
			old_oe <= bus.oe;
			if (rd_start) begin
				req_tog    <= ~req_tog;
				rd_pending <= 1'b1;
			end
			// Late data after oe already dropped is not acknowledged
			if (rd_done) begin
				rd_pending <= 1'b0;
				cart_dtack <= bus.oe;
			end else if (!bus.oe) begin
				cart_dtack <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_start)
			rd_addr <= map_addr;
		if (rd_done)
			cart_data <= rsp.rdata;
	end

	// Read only port
	assign req = '{addr: rd_addr, wdata: 16'h0000, we: 1'b0, req: req_tog};

endmodule

// ==== cartridge.sv ====
/*
 * Mega Drive cartridge controller top level
 * Download loader, header detection, ROM store and bus mapper
 */

`timescale 1ns/10ps
`include "cart_config.svh"

module cartridge (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cart_dl,
	input  cart_pkg::dl_word_t    dl,
	output logic                  cart_dl_wait,
	input  cart_pkg::cart_bus_t   bus,
	output logic [15:0]           cart_data,
	output logic                  cart_dtack,
	output cart_pkg::cart_quirk_t quirks
);

	cart_pkg::rom_req_t        req_a;
	cart_pkg::rom_rsp_t        rsp_a;
	cart_pkg::rom_req_t        req_b;
	cart_pkg::rom_rsp_t        rsp_b;
	logic [`CART_STORE_AW-1:0] rom_mask;

	// Download side, store port A
	cart_loader i_loader (
		.clk          (clk),
		.reset        (reset),
		.cart_dl      (cart_dl),
		.dl           (dl),
		.req          (req_a),
		.rsp          (rsp_a),
		.cart_dl_wait (cart_dl_wait),
		.rom_mask     (rom_mask)
	);

	cart_detect i_detect (
		.clk     (clk),
		.reset   (reset),
		.cart_dl (cart_dl),
		.dl      (dl),
		.quirks  (quirks)
	);

	rom_store i_store (
		.clk   (clk),
		.req_a (req_a),
		.rsp_a (rsp_a),
		.req_b (req_b),
		.rsp_b (rsp_b)
	);

	// CPU side, store port B
	cart_mapper i_mapper (
		.clk        (clk),
		.reset      (reset),
		.bus        (bus),
		.rom_mask   (rom_mask),
		.req        (req_b),
		.rsp        (rsp_b),
		.cart_data  (cart_data),
		.cart_dtack (cart_dtack)
	);

endmodule

// ==== cartridge_sva.sv ====
/*
 * Cartridge controller assertions
 * Dtack release, download back-pressure and reset state
 */

`timescale 1ns/10ps

module cartridge_sva (
	input logic                clk,
	input logic                reset,
	input cart_pkg::dl_word_t  dl,
	input logic                cart_dl,
	input logic                cart_dl_wait,
	input cart_pkg::cart_bus_t bus,
	input logic                cart_dtack
);

	// Number of assertion failures so far
	int assert_fails;

	// Dtack released once the CPU drops oe
	a_dtack_release: assert property (@(posedge clk) disable iff (reset)
		!bus.oe |=> !cart_dtack)
		else begin
			assert_fails++;
			$error("cart_dtack still high one cycle after oe went low");
		end

	// Each download beat is absorbed within three cycles
	a_wait_bound: assert property (@(posedge clk) disable iff (reset)
		(cart_dl && dl.wr) |-> ##[1:3] !cart_dl_wait)
		else begin
			assert_fails++;
			$error("cart_dl_wait held longer than three cycles after a beat");
		end

	a_wait_reset: assert property (@(posedge clk) reset |=> !cart_dl_wait)
		else begin
			assert_fails++;
			$error("cart_dl_wait high in the cycle after reset");
		end

endmodule

bind cartridge cartridge_sva i_sva (
	.clk          (clk),
	.reset        (reset),
	.dl           (dl),
	.cart_dl      (cart_dl),
	.cart_dl_wait (cart_dl_wait),
	.bus          (bus),
	.cart_dtack   (cart_dtack)
);

// ==== tb_cartridge.sv ====
/*
 * Cartridge controller testbench
 * Directed tests for download, readback, masking, banking, reset and detection
 */

`timescale 1ns/10ps
`include "cart_config.svh"

module tb_cartridge;

	localparam int STORE_WORDS = 2**`CART_STORE_AW;
	localparam int WIN_WORDS   = 2**`CART_WIN_AW;
	localparam int TIMEOUT     = 100;
	// Word address of the first bank register, 0xA130F0 on the byte bus
	localparam logic [22:0] BANK_REG_BASE = 23'h509878;

	logic                  clk;
	logic                  reset;
	logic                  cart_dl;
	cart_pkg::dl_word_t    dl;
	logic                  cart_dl_wait;
	cart_pkg::cart_bus_t   bus;
	logic [15:0]           cart_data;
	logic                  cart_dtack;
	cart_pkg::cart_quirk_t quirks;

	logic [15:0] image [STORE_WORDS];
	int          data_errors;
	int          quirk_errors;
	int          bit_errors;
	int          timeouts;
	int          assert_errors;

	cartridge i_dut (
		.clk          (clk),
		.reset        (reset),
		.cart_dl      (cart_dl),
		.dl           (dl),
		.cart_dl_wait (cart_dl_wait),
		.bus          (bus),
		.cart_data    (cart_data),
		.cart_dtack   (cart_dtack),
		.quirks       (quirks)
	);

	always #2 clk = ~clk;

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic check_data(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		if (act !== exp) begin
			data_errors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_quirks(input cart_pkg::cart_quirk_t exp,
		input cart_pkg::cart_quirk_t act);
		if (act !== exp) begin
			quirk_errors++;
			$display("** Error at %0t: quirks expected {%b,%b,%0d}, got {%b,%b,%0d}",
				$time, exp.ym2612_quirk, exp.gun_type, exp.gun_sensor_delay,
				act.ym2612_quirk, act.gun_type, act.gun_sensor_delay);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			bit_errors++;
			$display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// ========================================================================
	// Image and drive tasks
	// ========================================================================

	task automatic make_image(input int n);
		for (int i = 0; i < n; i++)
			image[i] = 16'($urandom);
	endtask

	// Even byte of the header sits in the low half of each host word
	task automatic place_serial(input logic [63:0] serial);
		int first;
		first = `CART_HDR_SERIAL_FIRST / 2;
		for (int w = 0; w < 4; w++)
			image[first + w] = {serial[55 - 16*w -: 8], serial[63 - 16*w -: 8]};
	endtask

	task automatic dl_image(input int n);
		int t;
		@(negedge clk);
		cart_dl = 1'b1;
		for (int i = 0; i < n; i++) begin
			dl.addr = 25'(2 * i);
			dl.data = image[i];
			dl.wr   = 1'b1;
			@(negedge clk);
			dl.wr = 1'b0;
			check_bit("cart_dl_wait", 1'b1, cart_dl_wait);
			t = 0;
			while (cart_dl_wait && t < TIMEOUT) begin
				@(negedge clk);
				t++;
			end
			if (cart_dl_wait) begin
				timeouts++;
				$display("Timeout: cart_dl_wait never fell after download word %0d", i);
			end
		end
		cart_dl = 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_dtack(input logic [22:0] addr);
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!cart_dtack && t < TIMEOUT);
		if (!cart_dtack) begin
			timeouts++;
			$display("Timeout: no cart_dtack for the read at word address %h", addr);
		end
	endtask

	task automatic bus_read(input logic [22:0] addr, output logic [15:0] data);
		@(negedge clk);
		bus.addr = addr;
		bus.cs   = 1'b1;
		bus.oe   = 1'b1;
		wait_dtack(addr);
		data   = cart_data;
		bus.oe = 1'b0;
		bus.cs = 1'b0;
		@(negedge clk);
		check_bit("cart_dtack", 1'b0, cart_dtack);
	endtask

	task automatic bus_write(input logic [22:0] addr, input logic [15:0] data);
		@(negedge clk);
		bus.addr     = addr;
		bus.data_wr  = data;
		bus.lwr      = 1'b1;
		bus.time_sel = 1'b1;
		@(negedge clk);
		bus.lwr      = 1'b0;
		bus.time_sel = 1'b0;
	endtask

	task automatic read_check(input int addr, input logic [15:0] exp);
		logic [15:0] got;
		bus_read(23'(addr), got);
		check_data($sformatf("cart_data @%h", addr), exp, got);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic test_linear();
		make_image(WIN_WORDS);
		dl_image(WIN_WORDS);
		for (int i = 0; i < WIN_WORDS; i++)
			read_check(i, image[i]);
	endtask

	// 256-word image leaves a mask of 255
	task automatic test_mask_wrap();
		for (int i = 0; i < WIN_WORDS; i++)
			read_check(i + WIN_WORDS, image[i]);
	endtask

	task automatic detect_one(input logic [63:0] serial, input cart_pkg::cart_quirk_t exp);
		make_image(WIN_WORDS);
		place_serial(serial);
		dl_image(WIN_WORDS);
		check_quirks(exp, quirks);
	endtask

	task automatic test_detect();
		detect_one("T-35036 ", '{1'b1, 1'b0, 8'd44});
		detect_one("T-95096-", '{1'b0, 1'b1, 8'd52});
		detect_one("T-99999 ", '{1'b0, 1'b0, `CART_GUN_DELAY_DEFAULT});
	endtask

	task automatic test_throttle();
		make_image(64);
		dl_image(64);
		read_check(63, image[63]);
	endtask

	// Light-gun title in the header, so the later reset has settings to clear
	task automatic test_banking();
		int k;
		int v;
		make_image(STORE_WORDS);
		place_serial("T-95096-");
		dl_image(STORE_WORDS);
		check_quirks('{1'b0, 1'b1, 8'd52}, quirks);
		k = 1 + ($urandom % 7);
		v = 8 + ($urandom % 56);
		bus_write(BANK_REG_BASE + 23'(k), 16'(v));
		for (int o = 0; o < WIN_WORDS; o += 15) begin
			read_check(k * WIN_WORDS + o, image[v * WIN_WORDS + o]);
			for (int j = 0; j < 8; j++)
				if (j != k)
					read_check(j * WIN_WORDS + o, image[j * WIN_WORDS + o]);
		end
	endtask

	// Reset arrives while a read holds dtack high
	task automatic test_reset();
		@(negedge clk);
		bus.addr = '0;
		bus.cs   = 1'b1;
		bus.oe   = 1'b1;
		wait_dtack('0);
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset  = 1'b0;
		bus.oe = 1'b0;
		bus.cs = 1'b0;
		check_bit("cart_dl_wait", 1'b0, cart_dl_wait);
		check_bit("cart_dtack", 1'b0, cart_dtack);
		check_quirks('{1'b0, 1'b0, `CART_GUN_DELAY_DEFAULT}, quirks);
		for (int o = 0; o < WIN_WORDS; o += 15)
			for (int j = 0; j < 8; j++)
				read_check(j * WIN_WORDS + o, image[j * WIN_WORDS + o]);
	endtask

	initial begin
		clk     = 1'b0;
		reset   = 1'b1;
		cart_dl = 1'b0;
		dl      = '0;
		bus     = '0;
		void'($urandom(35));
		repeat (2) @(negedge clk);
		reset = 1'b0;

		test_linear();
		test_mask_wrap();
		test_detect();
		test_throttle();
		test_banking();
		test_reset();

		assert_errors = i_dut.i_sva.assert_fails;
		$display("Errors: data %0d, quirks %0d, bits %0d, timeouts %0d, assertions %0d",
			data_errors, quirk_errors, bit_errors, timeouts, assert_errors);
		if (data_errors + quirk_errors + bit_errors + timeouts + assert_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+.
cart_pkg.sv
cart_loader.sv
cart_detect.sv
rom_store.sv
cart_mapper.sv
cartridge.sv
cartridge_sva.sv
tb_cartridge.sv
